// File: src/sensorPkg.sv
`default_nettype none

package sensorPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and data types
  localparam int DataWidth = 8;

  typedef logic [DataWidth-1:0]   sensorByteT;
  typedef logic [2*DataWidth-1:0] sensorWordT;  // {high byte, low byte}
  typedef logic [31:0]            timerT;
  typedef logic [7:0]             sensAddrT;
  typedef logic [2:0]             hostAddrT;
  typedef logic [15:0]            hostDataT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sensor register addresses
  localparam sensAddrT LocalLoAddr  = 8'h00;
  localparam sensAddrT LocalHiAddr  = 8'h01;
  localparam sensAddrT RemoteLoAddr = 8'h10;
  localparam sensAddrT RemoteHiAddr = 8'h11;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host register map
  localparam hostAddrT RegCtrl     = 3'd0;  // bit 0 enable
  localparam hostAddrT RegPresetL  = 3'd1;
  localparam hostAddrT RegPresetH  = 3'd2;
  localparam hostAddrT RegValueL   = 3'd3;
  localparam hostAddrT RegValueR   = 3'd4;
  localparam hostAddrT RegStatus   = 3'd5;  // bit 0 pending (w1c), bit 1 error
  localparam hostAddrT RegPassAddr = 3'd6;
  localparam hostAddrT RegPassData = 3'd7;  // access runs a sensor-bus cycle

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machines
  typedef enum logic [2:0] {
    stDisabled,
    stIdle,
    stQueryLocal,
    stWait1,
    stQueryRemote,
    stNotify,
    stError
  } sensorStateT;

  typedef enum logic [1:0] {
    msIdle,
    msReadLo,
    msReadHi,
    msDone
  } measureStateT;

endpackage

`default_nettype wire

// File: src/sensorWbIf.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic, single transfer only
interface sensorWbIf
  import sensorPkg::*;
();

  sensAddrT   adr;
  sensorByteT datMosi;
  sensorByteT datMiso;
  logic       we;
  logic       cyc;
  logic       stb;
  logic       ack;
  logic       err;

  modport master (
    output adr, datMosi, we, cyc, stb,
    input  datMiso, ack, err
  );

  modport slave (
    input  adr, datMosi, we, cyc, stb,
    output datMiso, ack, err
  );

endinterface

`default_nettype wire

// File: src/sensorFsm.sv
`timescale 1ns/1ps
`default_nettype none

module sensorFsm
  import sensorPkg::*;
(
  input  wire logic       Clk_i,
  input  wire logic       SensorFSM_TimerPreset,
  input  wire logic       enable_i,
  input  wire hostDataT   presetL_i,
  input  wire hostDataT   presetH_i,
  input  wire logic       measDone_i,
  input  wire logic       measError_i,
  input  wire sensorByteT measByte0_i,
  input  wire sensorByteT measByte1_i,
  output logic            queryLocal_o,
  output logic            queryRemote_o,
  output logic            cpuIntr_o,
  output logic            inError_o,
  output sensorWordT      valueL_o,
  output sensorWordT      valueR_o
);

  sensorStateT state;
  sensorStateT nextState;
  timerT       timer;
  logic        timerLoad;
  logic        timerEnable;
  logic        timerOvfl;
  logic        storeLocal;
  logic        storeRemote;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencing
  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
      state <= stDisabled;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState     = state;
    timerLoad     = 1'b0;
    timerEnable   = 1'b0;
    queryLocal_o  = 1'b0;
    queryRemote_o = 1'b0;
    storeLocal    = 1'b0;
    storeRemote   = 1'b0;
    cpuIntr_o     = 1'b0;
    case (state)
      stDisabled:
      begin
        if (enable_i)
        begin
          timerLoad = 1'b1;
          nextState = stIdle;
        end
      end
      stIdle:
      begin
        if (!enable_i)
          nextState = stDisabled;
        else if (timerOvfl)
        begin
          queryLocal_o = 1'b1;
          nextState    = stQueryLocal;
        end
        else
          timerEnable = 1'b1;
      end
      stQueryLocal, stQueryRemote:
      begin
        if (measError_i)
        begin
          cpuIntr_o = 1'b1;  // report the failure once, then park
          nextState = stError;
        end
        else if (measDone_i)
        begin
          storeLocal  = (state == stQueryLocal);
          storeRemote = (state == stQueryRemote);
          nextState   = (state == stQueryLocal) ? stWait1 : stNotify;
        end
      end
      stWait1:
      begin
        queryRemote_o = 1'b1;
        nextState     = stQueryRemote;
      end
      stNotify:
      begin
        timerLoad = 1'b1;  // next interval starts here
        cpuIntr_o = 1'b1;
        nextState = stIdle;
      end
      stError:
      begin
        if (!enable_i)
          nextState = stDisabled;
      end
      default: nextState = stDisabled;
    endcase
  end

  assign inError_o = (state == stError);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // interval timer and results
  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
      timer <= '0;
    else if (timerLoad)
      timer <= {presetH_i, presetL_i};
    else if (timerEnable)
      timer <= timer - timerT'(1);
  end

  assign timerOvfl = (timer == '0);

  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      valueL_o <= '0;  // results are host visible, read zero after reset
      valueR_o <= '0;
    end
    else
    begin
      if (storeLocal)
        valueL_o <= {measByte1_i, measByte0_i};
      if (storeRemote)
        valueR_o <= {measByte1_i, measByte0_i};
    end
  end

  aQueryExclusive: assert property (@(posedge Clk_i) disable iff (SensorFSM_TimerPreset)
    !(queryLocal_o && queryRemote_o));

endmodule

`default_nettype wire

// File: src/measureFsm.sv
`timescale 1ns/1ps
`default_nettype none

module measureFsm
  import sensorPkg::*;
(
  input  wire logic  Clk_i,
  input  wire logic  SensorFSM_TimerPreset,
  input  wire logic  queryLocal_i,
  input  wire logic  queryRemote_i,
  sensorWbIf.master  bus,
  output logic       done_o,
  output logic       error_o,
  output sensorByteT byte0_o,
  output sensorByteT byte1_o
);

  measureStateT state;
  logic         cycQ;
  logic         remoteQ;  // address pair of the running query
  logic         busAck;
  logic         busErr;

  assign busAck = cycQ && bus.ack;
  assign busErr = cycQ && bus.err;

  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      state   <= msIdle;
      cycQ    <= 1'b0;
      error_o <= 1'b0;
    end
    else
    begin
      error_o <= 1'b0;
      case (state)
        msIdle:
        begin
          if (queryLocal_i || queryRemote_i)
          begin
            cycQ  <= 1'b1;
            state <= msReadLo;
          end
        end
        msReadLo, msReadHi:
        begin
          if (!cycQ)
            cycQ <= 1'b1;  // one idle cycle between the two reads
          else if (busErr)
          begin
            cycQ    <= 1'b0;
            error_o <= 1'b1;
            state   <= msIdle;
          end
          else if (busAck)
          begin
            cycQ  <= 1'b0;
            state <= (state == msReadLo) ? msReadHi : msDone;
          end
        end
        default: state <= msIdle;  // msDone lasts one cycle
      endcase
    end
  end

  assign done_o = (state == msDone);

  // bytes are held from done until the next query
  always_ff @(posedge Clk_i)
  begin
    if (state == msIdle && (queryLocal_i || queryRemote_i))
      remoteQ <= queryRemote_i;
    if (state == msReadLo && busAck)
      byte0_o <= bus.datMiso;
    if (state == msReadHi && busAck)
      byte1_o <= bus.datMiso;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus drive, reads only
  always_comb
  begin
    if (state == msReadHi)
      bus.adr = remoteQ ? RemoteHiAddr : LocalHiAddr;
    else
      bus.adr = remoteQ ? RemoteLoAddr : LocalLoAddr;
  end

  assign bus.cyc     = cycQ;
  assign bus.stb     = cycQ;
  assign bus.we      = 1'b0;
  assign bus.datMosi = '0;

  // sensorFsm must wait for done or error before the next query
  aNoQueryWhenBusy: assert property (@(posedge Clk_i) disable iff (SensorFSM_TimerPreset)
    (queryLocal_i || queryRemote_i) |-> (state == msIdle));

endmodule

`default_nettype wire

// File: src/wbArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wbArbiter
  import sensorPkg::*;
(
  input wire logic  Clk_i,
  input wire logic  SensorFSM_TimerPreset,
  sensorWbIf.slave  m0,  // measurement
  sensorWbIf.slave  m1,  // pass-through
  sensorWbIf.master s
);

  logic gntQ;    // 0 selects m0
  logic busCyc;

  assign busCyc = gntQ ? m1.cyc : m0.cyc;

  // re-arbitrate only while the granted master is idle
  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
      gntQ <= 1'b0;
    else if (!busCyc)
    begin
      if (m0.cyc)
        gntQ <= 1'b0;  // measurement wins a tie
      else if (m1.cyc)
        gntQ <= 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request path
  assign s.cyc     = busCyc;
  assign s.stb     = gntQ ? m1.stb : m0.stb;
  assign s.adr     = gntQ ? m1.adr : m0.adr;
  assign s.we      = gntQ ? m1.we : m0.we;
  assign s.datMosi = gntQ ? m1.datMosi : m0.datMosi;

  // response path, the waiting master sees nothing
  assign m0.datMiso = s.datMiso;
  assign m1.datMiso = s.datMiso;
  assign m0.ack     = !gntQ && s.ack;
  assign m0.err     = !gntQ && s.err;
  assign m1.ack     = gntQ && s.ack;
  assign m1.err     = gntQ && s.err;

  // a granted cycle stays on the same master and address until ack or err
  aGrantStable: assert property (@(posedge Clk_i) disable iff (SensorFSM_TimerPreset)
    s.cyc && !(s.ack || s.err) |=> s.cyc && $stable(gntQ) && $stable(s.adr));

endmodule

`default_nettype wire

// File: src/hostRegs.sv
`timescale 1ns/1ps
`default_nettype none

module hostRegs
  import sensorPkg::*;
(
  input  wire logic       Clk_i,
  input  wire logic       SensorFSM_TimerPreset,
  input  wire hostAddrT   hostAdr_i,
  input  wire hostDataT   hostDat_i,
  input  wire logic       hostWe_i,
  input  wire logic       hostCyc_i,
  input  wire logic       hostStb_i,
  output hostDataT        hostDat_o,
  output logic            hostAck_o,
  output logic            irq_o,
  sensorWbIf.master       pass,
  input  wire logic       cpuIntr_i,
  input  wire logic       inError_i,
  input  wire sensorWordT valueL_i,
  input  wire sensorWordT valueR_i,
  output logic            enable_o,
  output hostDataT        presetL_o,
  output hostDataT        presetH_o
);

  logic       hostReq;
  logic       passSel;
  logic       regWrite;
  logic       passStart;
  logic       passEnd;
  logic       pendQ;
  logic       passCycQ;
  logic       passWeQ;
  sensAddrT   passAddrQ;
  sensorByteT passDatQ;
  sensorByteT passRdQ;

  assign hostReq   = hostCyc_i && hostStb_i;
  assign passSel   = (hostAdr_i == RegPassData);
  assign regWrite  = hostReq && hostWe_i && !passSel && !hostAck_o;
  assign passStart = hostReq && passSel && !passCycQ && !hostAck_o;
  assign passEnd   = passCycQ && (pass.ack || pass.err);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // configuration and status
  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      enable_o  <= 1'b0;
      presetL_o <= '0;
      presetH_o <= '0;
      passAddrQ <= '0;
      pendQ     <= 1'b0;
    end
    else
    begin
      if (regWrite)
      begin
        case (hostAdr_i)
          RegCtrl:     enable_o  <= hostDat_i[0];
          RegPresetL:  presetL_o <= hostDat_i;
          RegPresetH:  presetH_o <= hostDat_i;
          RegPassAddr: passAddrQ <= hostDat_i[DataWidth-1:0];
          RegStatus:
          begin
            if (hostDat_i[0])
              pendQ <= 1'b0;
          end
          default: ;
        endcase
      end
      if (cpuIntr_i)
        pendQ <= 1'b1;  // a new event beats a clear in the same cycle
    end
  end

  assign irq_o = pendQ;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host ack and pass-through cycle
  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      hostAck_o <= 1'b0;
      passCycQ  <= 1'b0;
    end
    else
    begin
      hostAck_o <= (hostReq && !passSel && !hostAck_o) || passEnd;
      if (passStart)
        passCycQ <= 1'b1;
      else if (passEnd)
        passCycQ <= 1'b0;
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (passStart)
    begin
      passWeQ  <= hostWe_i;
      passDatQ <= hostDat_i[DataWidth-1:0];
    end
    if (passEnd)
      passRdQ <= pass.datMiso;
  end

  assign pass.cyc     = passCycQ;
  assign pass.stb     = passCycQ;
  assign pass.we      = passWeQ;
  assign pass.adr     = passAddrQ;
  assign pass.datMosi = passDatQ;

  // read mux, valid while the host holds the address
  always_comb
  begin
    case (hostAdr_i)
      RegCtrl:     hostDat_o = {15'd0, enable_o};
      RegPresetL:  hostDat_o = presetL_o;
      RegPresetH:  hostDat_o = presetH_o;
      RegValueL:   hostDat_o = valueL_i;
      RegValueR:   hostDat_o = valueR_i;
      RegStatus:   hostDat_o = {14'd0, inError_i, pendQ};
      RegPassAddr: hostDat_o = {{DataWidth{1'b0}}, passAddrQ};
      default:     hostDat_o = {{DataWidth{1'b0}}, passRdQ};
    endcase
  end

  aAckInCycle: assert property (@(posedge Clk_i) disable iff (SensorFSM_TimerPreset)
    hostAck_o |-> hostStb_i);

endmodule

`default_nettype wire

// File: src/sensorSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module sensorSubsys
  import sensorPkg::*;
(
  input  wire logic       Clk_i,
  input  wire logic       SensorFSM_TimerPreset,
  // host wishbone slave
  input  wire hostAddrT   hostAdr_i,
  input  wire hostDataT   hostDat_i,
  input  wire logic       hostWe_i,
  input  wire logic       hostCyc_i,
  input  wire logic       hostStb_i,
  output hostDataT        hostDat_o,
  output logic            hostAck_o,
  output logic            irq_o,
  // sensor register bus
  output sensAddrT        sensAdr_o,
  output sensorByteT      sensDat_o,
  input  wire sensorByteT sensDat_i,
  output logic            sensWe_o,
  output logic            sensCyc_o,
  output logic            sensStb_o,
  input  wire logic       sensAck_i,
  input  wire logic       sensErr_i
);

  logic       queryLocal;
  logic       queryRemote;
  logic       measDone;
  logic       measError;
  sensorByteT measByte0;
  sensorByteT measByte1;
  logic       cpuIntr;
  logic       inError;
  sensorWordT valueL;
  sensorWordT valueR;
  logic       enable;
  hostDataT   presetL;
  hostDataT   presetH;

  sensorWbIf measBus ();
  sensorWbIf passBus ();
  sensorWbIf sensBus ();

  sensorFsm uSensorFsm (
    .Clk_i                 (Clk_i),
    .SensorFSM_TimerPreset (SensorFSM_TimerPreset),
    .enable_i              (enable),
    .presetL_i             (presetL),
    .presetH_i             (presetH),
    .measDone_i            (measDone),
    .measError_i           (measError),
    .measByte0_i           (measByte0),
    .measByte1_i           (measByte1),
    .queryLocal_o          (queryLocal),
    .queryRemote_o         (queryRemote),
    .cpuIntr_o             (cpuIntr),
    .inError_o             (inError),
    .valueL_o              (valueL),
    .valueR_o              (valueR)
  );

  measureFsm uMeasureFsm (
    .Clk_i                 (Clk_i),
    .SensorFSM_TimerPreset (SensorFSM_TimerPreset),
    .queryLocal_i          (queryLocal),
    .queryRemote_i         (queryRemote),
    .bus                   (measBus.master),
    .done_o                (measDone),
    .error_o               (measError),
    .byte0_o               (measByte0),
    .byte1_o               (measByte1)
  );

  wbArbiter uWbArbiter (
    .Clk_i                 (Clk_i),
    .SensorFSM_TimerPreset (SensorFSM_TimerPreset),
    .m0                    (measBus.slave),
    .m1                    (passBus.slave),
    .s                     (sensBus.master)
  );

  hostRegs uHostRegs (
    .Clk_i                 (Clk_i),
    .SensorFSM_TimerPreset (SensorFSM_TimerPreset),
    .hostAdr_i             (hostAdr_i),
    .hostDat_i             (hostDat_i),
    .hostWe_i              (hostWe_i),
    .hostCyc_i             (hostCyc_i),
    .hostStb_i             (hostStb_i),
    .hostDat_o             (hostDat_o),
    .hostAck_o             (hostAck_o),
    .irq_o                 (irq_o),
    .pass                  (passBus.master),
    .cpuIntr_i             (cpuIntr),
    .inError_i             (inError),
    .valueL_i              (valueL),
    .valueR_i              (valueR),
    .enable_o              (enable),
    .presetL_o             (presetL),
    .presetH_o             (presetH)
  );

  // arbiter output to the plain sensor-bus ports
  assign sensAdr_o       = sensBus.adr;
  assign sensDat_o       = sensBus.datMosi;
  assign sensWe_o        = sensBus.we;
  assign sensCyc_o       = sensBus.cyc;
  assign sensStb_o       = sensBus.stb;
  assign sensBus.datMiso = sensDat_i;
  assign sensBus.ack     = sensAck_i;
  assign sensBus.err     = sensErr_i;

endmodule

`default_nettype wire

// File: verif/tbSensorSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module tbSensorSubsys
  import sensorPkg::*;
();

  localparam int          SmallPreset = 20;
  localparam int          MeasCycles  = SmallPreset + 60;  // interval plus four slow reads
  localparam int          HostTimeout = 64;
  localparam int          PassCount   = 6;
  localparam int          TestCycles  = 8 + 30 * 6 + 5 * MeasCycles + 3 * (SmallPreset + 2)
                                        + PassCount * 4 * 16 + MeasCycles + 60 + 3 * SmallPreset;
  localparam int          WatchdogCycles = 3 * TestCycles;
  localparam logic [31:0] LfsrSeed = 32'h66f1_4e91;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic       clk = 1'b0;
  logic       rstSync;
  hostAddrT   hostAdr;
  hostDataT   hostDatW;
  hostDataT   hostDatR;
  logic       hostWe;
  logic       hostCyc;
  logic       hostStb;
  logic       hostAck;
  logic       irq;
  sensAddrT   sensAdr;
  sensorByteT sensDatW;
  sensorByteT sensDatR = '0;
  logic       sensWe;
  logic       sensCyc;
  logic       sensStb;
  logic       sensAck = 1'b0;
  logic       sensErr = 1'b0;

  int errCount   = 0;
  int checkCount = 0;

  always #50 clk = ~clk;

  sensorSubsys DUT (
    .Clk_i                 (clk),
    .SensorFSM_TimerPreset (rstSync),
    .hostAdr_i             (hostAdr),
    .hostDat_i             (hostDatW),
    .hostWe_i              (hostWe),
    .hostCyc_i             (hostCyc),
    .hostStb_i             (hostStb),
    .hostDat_o             (hostDatR),
    .hostAck_o             (hostAck),
    .irq_o                 (irq),
    .sensAdr_o             (sensAdr),
    .sensDat_o             (sensDatW),
    .sensDat_i             (sensDatR),
    .sensWe_o              (sensWe),
    .sensCyc_o             (sensCyc),
    .sensStb_o             (sensStb),
    .sensAck_i             (sensAck),
    .sensErr_i             (sensErr)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sensor register bus device
  sensorByteT  mem [256];
  logic        errSet [256];
  logic [8:0]  busLog [$];  // {we, adr} per finished cycle
  int          cycCount = 0;
  logic        modelBusy;
  logic [1:0]  waitCnt;
  logic [31:0] lfsr = LfsrSeed;
  logic        bitLo;
  logic        bitHi;

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  function automatic sensorByteT fillByte(input int a);
    return sensorByteT'(a * 37 + 11);
  endfunction

  always @(posedge clk)
  begin
    if (rstSync)
    begin
      sensAck   <= 1'b0;
      sensErr   <= 1'b0;
      modelBusy <= 1'b0;
    end
    else if (sensAck || sensErr)
    begin
      sensAck <= 1'b0;  // master ends the cycle on this edge
      sensErr <= 1'b0;
    end
    else if (modelBusy)
    begin
      if (waitCnt != 0)
        waitCnt <= waitCnt - 2'd1;
      else
      begin
        modelBusy <= 1'b0;
        busLog.push_back({sensWe, sensAdr});
        cycCount++;
        if (errSet[sensAdr])
          sensErr <= 1'b1;
        else
        begin
          sensAck <= 1'b1;
          if (sensWe)
            mem[sensAdr] = sensDatW;
          else
            sensDatR <= mem[sensAdr];
        end
      end
    end
    else if (sensCyc && sensStb)
    begin
      bitLo = lfsr[0];
      lfsr  = lfsrNext(lfsr);
      bitHi = lfsr[0];
      lfsr  = lfsrNext(lfsr);
      waitCnt   <= {bitHi, bitLo} % 3;  // ack 1 to 3 cycles later
      modelBusy <= 1'b1;
    end
  end

  task automatic loadSensorBytes(input sensorByteT locLo, input sensorByteT locHi,
                                 input sensorByteT remLo, input sensorByteT remHi);
    mem[LocalLoAddr]  = locLo;
    mem[LocalHiAddr]  = locHi;
    mem[RemoteLoAddr] = remLo;
    mem[RemoteHiAddr] = remHi;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host access and compare
  task automatic hostAccess(input hostAddrT adr, input hostDataT dat, input logic we,
                            output hostDataT rd);
    int n;
    @(posedge clk);
    hostAdr  <= adr;
    hostDatW <= dat;
    hostWe   <= we;
    hostCyc  <= 1'b1;
    hostStb  <= 1'b1;
    n  = 0;
    rd = '0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!hostAck && n < HostTimeout);
    if (hostAck)
      rd = hostDatR;
    else
    begin
      errCount++;
      $display("host access to register %0d got no ack", adr);
    end
    @(posedge clk);
    hostCyc <= 1'b0;
    hostStb <= 1'b0;
    hostWe  <= 1'b0;
  endtask

  task automatic hostWrite(input hostAddrT adr, input hostDataT dat);
    hostDataT unused;
    hostAccess(adr, dat, 1'b1, unused);
  endtask

  task automatic hostRead(input hostAddrT adr, output hostDataT rd);
    hostAccess(adr, '0, 1'b0, rd);
  endtask

  task automatic compareWord(input string name, input sensorWordT got, input sensorWordT exp);
    checkCount++;
    if (got !== exp)
    begin
      errCount++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareByte(input string name, input sensorByteT got, input sensorByteT exp);
    checkCount++;
    if (got !== exp)
    begin
      errCount++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp)
    begin
      errCount++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic waitIrq(input int maxCycles);
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!irq && n < maxCycles);
    if (!irq)
    begin
      errCount++;
      $display("no interrupt within %0d cycles", maxCycles);
    end
  endtask

  task automatic checkResults(input sensorWordT expL, input sensorWordT expR);
    hostDataT rd;
    hostRead(RegValueL, rd);
    compareWord("RegValueL", rd, expL);
    hostRead(RegValueR, rd);
    compareWord("RegValueR", rd, expR);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  task automatic registerTest();
    hostDataT rd;
    int       a;
    for (a = 0; a < 7; a++)
    begin
      hostRead(hostAddrT'(a), rd);
      compareWord($sformatf("reg %0d after reset", a), rd, '0);
    end
    hostWrite(RegPresetH, 16'h0123);  // long interval, no query in this test
    hostWrite(RegPresetL, 16'hbeef);
    hostWrite(RegCtrl, 16'h0001);
    hostWrite(RegPassAddr, 16'h005a);
    hostRead(RegPresetH, rd);
    compareWord("RegPresetH", rd, 16'h0123);
    hostRead(RegPresetL, rd);
    compareWord("RegPresetL", rd, 16'hbeef);
    hostRead(RegCtrl, rd);
    compareWord("RegCtrl", rd, 16'h0001);
    hostRead(RegPassAddr, rd);
    compareWord("RegPassAddr", rd, 16'h005a);
    hostWrite(RegCtrl, 16'h0000);
    hostRead(RegCtrl, rd);
    compareWord("RegCtrl", rd, 16'h0000);
    hostWrite(RegPresetH, 16'h0000);
    if (cycCount != 0)
    begin
      errCount++;
      $display("sensor bus ran %0d cycles during register access", cycCount);
    end
  endtask

  task automatic singleMeasTest();
    hostDataT rd;
    loadSensorBytes(8'h34, 8'h12, 8'h78, 8'h56);
    hostWrite(RegPresetL, hostDataT'(SmallPreset));
    hostWrite(RegCtrl, 16'h0001);
    waitIrq(MeasCycles);
    checkResults({8'h12, 8'h34}, {8'h56, 8'h78});
    hostRead(RegStatus, rd);
    compareBit("RegStatus[0]", rd[0], 1'b1);
    compareBit("RegStatus[1]", rd[1], 1'b0);
    hostWrite(RegStatus, 16'h0001);
    @(negedge clk);
    compareBit("irq_o", irq, 1'b0);
  endtask

  task automatic periodicTest();
    sensAddrT order [4];
    order = '{LocalLoAddr, LocalHiAddr, RemoteLoAddr, RemoteHiAddr};
    loadSensorBytes(8'hcd, 8'hab, 8'h01, 8'hef);
    busLog.delete();
    waitIrq(MeasCycles);
    checkResults({8'hab, 8'hcd}, {8'hef, 8'h01});
    if (busLog.size() != 4)
    begin
      errCount++;
      $display("one measurement ran %0d sensor cycles instead of 4", busLog.size());
    end
    foreach (busLog[i])
    begin
      compareByte("sensAdr_o", busLog[i][7:0], order[i % 4]);
      compareBit("sensWe_o", busLog[i][8], 1'b0);
    end
    hostWrite(RegStatus, 16'h0001);
  endtask

  task automatic errorTest();
    hostDataT rd;
    int       count;
    errSet[RemoteHiAddr] = 1'b1;
    waitIrq(MeasCycles);
    hostRead(RegStatus, rd);
    compareBit("RegStatus[0]", rd[0], 1'b1);
    compareBit("RegStatus[1]", rd[1], 1'b1);
    count = cycCount;
    repeat (3 * (SmallPreset + 2)) @(negedge clk);
    if (cycCount != count)
    begin
      errCount++;
      $display("sensor bus kept running in the error state");
    end
    // recover with fresh bytes so the new results are visible
    errSet[RemoteHiAddr] = 1'b0;
    loadSensorBytes(8'h22, 8'h11, 8'h44, 8'h33);
    hostWrite(RegStatus, 16'h0001);
    hostWrite(RegCtrl, 16'h0000);
    hostWrite(RegCtrl, 16'h0001);
    waitIrq(MeasCycles);
    checkResults({8'h11, 8'h22}, {8'h33, 8'h44});
    hostRead(RegStatus, rd);
    compareBit("RegStatus[1]", rd[1], 1'b0);
  endtask

  task automatic passThroughTest();
    hostDataT   rd;
    sensAddrT   adr;
    sensorByteT dat;
    int         i;
    hostWrite(RegPresetL, 16'h0000);  // back-to-back measurements
    for (i = 0; i < PassCount; i++)
    begin
      adr = sensAddrT'(8'h40 + i * 5);
      dat = sensorByteT'(8'hc3 ^ (i * 29));
      hostWrite(RegPassAddr, {8'h00, adr});
      hostWrite(RegPassData, {8'h00, dat});
      compareByte("sensor byte", mem[adr], dat);
      hostRead(RegPassData, rd);
      compareByte("RegPassData", rd[7:0], dat);
    end
    hostWrite(RegPassAddr, 16'h0020);
    hostRead(RegPassData, rd);
    compareByte("RegPassData", rd[7:0], fillByte(8'h20));
    hostWrite(RegStatus, 16'h0001);
    waitIrq(MeasCycles);
    checkResults({8'h11, 8'h22}, {8'h33, 8'h44});
  endtask

  task automatic disableTest();
    int count;
    hostWrite(RegPresetL, hostDataT'(SmallPreset));
    hostWrite(RegCtrl, 16'h0000);
    repeat (60) @(negedge clk);  // a running measurement finishes first
    hostWrite(RegStatus, 16'h0001);
    count = cycCount;
    repeat (3 * SmallPreset) @(negedge clk);
    if (cycCount != count)
    begin
      errCount++;
      $display("sensor bus cycles started while disabled");
    end
    compareBit("irq_o", irq, 1'b0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // run
  initial
  begin
    rstSync  = 1'b1;
    hostAdr  = '0;
    hostDatW = '0;
    hostWe   = 1'b0;
    hostCyc  = 1'b0;
    hostStb  = 1'b0;
    for (int a = 0; a < 256; a++)
    begin
      mem[a]    = fillByte(a);
      errSet[a] = 1'b0;
    end
    repeat (8) @(posedge clk);
    rstSync <= 1'b0;
    @(negedge clk);
    compareBit("sensCyc_o", sensCyc, 1'b0);
    compareBit("sensStb_o", sensStb, 1'b0);
    compareBit("hostAck_o", hostAck, 1'b0);
    compareBit("irq_o", irq, 1'b0);
    registerTest();
    singleMeasTest();
    periodicTest();
    errorTest();
    passThroughTest();
    disableTest();
    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WatchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
src/sensorPkg.sv
src/sensorWbIf.sv
src/sensorFsm.sv
src/measureFsm.sv
src/wbArbiter.sv
src/hostRegs.sv
src/sensorSubsys.sv
verif/tbSensorSubsys.sv

// File: Bender.yml
package:
  name: sensor_subsys

sources:
  - src/sensorPkg.sv
  - src/sensorWbIf.sv
  - src/sensorFsm.sv
  - src/measureFsm.sv
  - src/wbArbiter.sv
  - src/hostRegs.sv
  - src/sensorSubsys.sv
  - target: test
    files:
      - verif/tbSensorSubsys.sv
